//--- uart_echo_top.f
hdl/uart_echo_pkg.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_echo_top.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_echo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the echo testbench with verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_uart_echo \
    -f uart_echo_top.f \
    -Mdir obj_dir

# the log is searched even when the simulator stops early
./obj_dir/Vtb_uart_echo | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- testbench/tb_uart_echo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_echo;

    localparam int CLK_FREQ_HZ  = 10_000_000;
    localparam int BAUD         = 1_000_000;
    localparam int FIFO_DEPTH   = 4;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD; // 10
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;  // start + 8 data + stop
    localparam int TOTAL_FRAMES = 8 + 3 + (FIFO_DEPTH + 2) + 2;
    localparam int TIMEOUT_CYCLES = 3 * TOTAL_FRAMES * FRAME_CLKS + 200;

    logic clk;
    logic locked;
    logic rxd_i;
    logic cts_i;
    logic txd_o;
    logic overrun_o;
    logic frame_err_o;

    logic [7:0] exp_q [$];   // bytes owed on txd_o oldest first
    int         seed;
    int         err_count;
    int         errs_at_start;
    int         tests_passed;
    int         tests_failed;
    int         frames_seen;   // frames decoded by the monitor
    int         cycle_cnt;
    logic       in_frame;      // monitor busy with a frame

    tb_clock_gen #(.PERIOD_NS(100)) tb_clock_gen_inst (.clk_o(clk));

    uart_echo_top #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD        (BAUD),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uart_echo_top_inst (
        .clk_i       (clk),
        .locked      (locked),
        .rxd_i       (rxd_i),
        .cts_i       (cts_i),
        .txd_o       (txd_o),
        .overrun_o   (overrun_o),
        .frame_err_o (frame_err_o)
    );

    // one bit time on rxd_i from a falling edge
    task automatic drive_bit(input logic level);
        rxd_i = level;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // 8n1 frame where good_stop low gives a framing error
    task automatic send_frame(input logic [7:0] data, input logic good_stop);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]); // lsb first
        end
        drive_bit(good_stop);
        rxd_i = 1'b1;
    endtask

    function automatic logic [7:0] next_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // waits until every owed byte has been echoed
    task automatic wait_echo_drained();
        while (exp_q.size() != 0 || in_frame) begin
            @(negedge clk);
        end
    endtask

    task automatic check_line_idle(input int cycles);
        int i;
        int busy;
        busy = 0;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (txd_o !== 1'b1) busy++;
        end
        assert (busy == 0) else begin
            err_count++;
            $display("ERROR at %0t ns: txd_o left idle on %0d of %0d cycles", $time, busy, cycles);
        end
    endtask

    task automatic report_test(input string name);
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("test %s : pass", name);
        end else begin
            tests_failed++;
            $display("test %s : fail, %0d errors", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    // serial monitor on txd_o sampling at bit middles
    initial begin : txd_monitor
        logic [7:0] got;
        logic [7:0] want;
        int i;
        in_frame = 1'b0;
        frames_seen = 0;
        wait (locked === 1'b1);
        forever begin
            @(negedge clk);
            if (txd_o === 1'b0) begin
                in_frame = 1'b1;
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk); // mid start bit
                assert (txd_o === 1'b0) else begin
                    err_count++;
                    $display("ERROR at %0t ns: start bit on txd_o did not last", $time);
                end
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    got[i] = txd_o;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (txd_o === 1'b1) else begin
                    err_count++;
                    $display("MISMATCH at %0t ns: txd_o stop bit expected 1 got %b", $time, txd_o);
                end
                frames_seen++;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("ERROR at %0t ns: unexpected frame 0x%02h on txd_o", $time, got);
                end else begin
                    want = exp_q.pop_front();
                    assert (got === want) else begin
                        err_count++;
                        $display("MISMATCH at %0t ns: txd_o expected 0x%02h got 0x%02h",
                                 $time, want, got);
                    end
                end
                in_frame = 1'b0;
            end
        end
    end

    // flags are sticky until reset
    a_overrun_sticky : assert property (
        @(posedge clk) disable iff (!locked) overrun_o |=> overrun_o
    ) else begin
        err_count++;
        $display("ERROR at %0t ns: overrun_o dropped without a reset", $time);
    end

    a_frame_err_sticky : assert property (
        @(posedge clk) disable iff (!locked) frame_err_o |=> frame_err_o
    ) else begin
        err_count++;
        $display("ERROR at %0t ns: frame_err_o dropped without a reset", $time);
    end

    a_reset_state : assert property (
        @(posedge clk) $rose(locked) |-> (txd_o && !overrun_o && !frame_err_o)
    ) else begin
        err_count++;
        $display("ERROR at %0t ns: outputs not at rest when reset ended", $time);
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [7:0] b;
        int i;
        int frames_before;
        seed = 27809;
        err_count = 0;
        errs_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt = 0;
        locked = 1'b0;
        rxd_i = 1'b1;   // line at rest
        cts_i = 1'b0;
        repeat (4) @(negedge clk);
        locked = 1'b1;
        repeat (4) @(negedge clk); // synchronizer release plus margin

        assert (txd_o === 1'b1 && overrun_o === 1'b0 && frame_err_o === 1'b0) else begin
            err_count++;
            $display("ERROR at %0t ns: outputs not idle after reset", $time);
        end
        report_test("reset state");

        // back to back echo
        cts_i = 1'b1;
        frames_before = frames_seen;
        for (i = 0; i < 8; i++) begin
            b = next_byte();
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        wait_echo_drained();
        assert (frames_seen - frames_before == 8 && exp_q.size() == 0) else begin
            err_count++;
            $display("ERROR at %0t ns: echo count wrong, saw %0d frames", $time,
                     frames_seen - frames_before);
        end
        report_test("echo");

        // cts low holds the bytes in the fifo
        cts_i = 1'b0;
        for (i = 0; i < 3; i++) begin
            b = next_byte();
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        check_line_idle(50);
        cts_i = 1'b1;
        wait_echo_drained();
        assert (overrun_o === 1'b0) else begin
            err_count++;
            $display("ERROR at %0t ns: overrun_o set with only 3 bytes buffered", $time);
        end
        report_test("flow control");

        // two more than the fifo holds so the last two are lost
        cts_i = 1'b0;
        frames_before = frames_seen;
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            b = next_byte();
            if (i < FIFO_DEPTH) exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        repeat (2) @(negedge clk);
        assert (overrun_o === 1'b1) else begin
            err_count++;
            $display("ERROR at %0t ns: overrun_o not set after a full buffer", $time);
        end
        cts_i = 1'b1;
        wait_echo_drained();
        check_line_idle(2 * FRAME_CLKS);
        assert (frames_seen - frames_before == FIFO_DEPTH) else begin
            err_count++;
            $display("ERROR at %0t ns: %0d frames echoed after overrun, wanted %0d", $time,
                     frames_seen - frames_before, FIFO_DEPTH);
        end
        report_test("overrun");

        // bad stop bit followed by one good byte
        frames_before = frames_seen;
        send_frame(next_byte(), 1'b0);
        drive_bit(1'b1); // rest so rx resyncs
        assert (frame_err_o === 1'b1) else begin
            err_count++;
            $display("ERROR at %0t ns: frame_err_o not set by a low stop bit", $time);
        end
        b = next_byte();
        exp_q.push_back(b);
        send_frame(b, 1'b1);
        wait_echo_drained();
        assert (frames_seen - frames_before == 1 && frame_err_o === 1'b1) else begin
            err_count++;
            $display("ERROR at %0t ns: bad frame echoed or frame_err_o lost", $time);
        end
        report_test("framing error");

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock for the testbench
module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    localparam int HALF_NS = PERIOD_NS / 2; // 50 ns high, 50 ns low

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

// serial echo: rx -> byte fifo -> tx
module uart_echo_top
    import uart_echo_pkg::*;
#(
    parameter int CLK_FREQ_HZ = 56060610,
    parameter int BAUD        = 9600,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic clk_i,
    input  logic locked,      // active low reset source
    input  logic rxd_i,
    input  logic cts_i,
    output logic txd_o,
    output logic overrun_o,   // sticky, buffer overflowed
    output logic frame_err_o  // sticky, bad stop bit received
);

    logic [1:0] rst_sync_q;   // reset synchronizer chain
    logic       rst_n;

    logic       rx_valid;     // rx -> fifo
    uart_byte_t rx_data;
    logic       avail;        // fifo -> tx
    uart_byte_t head_data;
    logic       take;         // tx -> fifo

    // assert at once, release two edges after locked rises
    always_ff @(posedge clk_i or negedge locked) begin
        if (!locked) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign rst_n = rst_sync_q[1];

    uart_rx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD        (BAUD)
    ) uart_rx_inst (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .rxd_i       (rxd_i),
        .rx_valid_o  (rx_valid),
        .rx_data_o   (rx_data),
        .frame_err_o (frame_err_o)
    );

    byte_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) byte_fifo_inst (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .wr_valid_i  (rx_valid),
        .wr_data_i   (rx_data),
        .take_i      (take),
        .avail_o     (avail),
        .head_data_o (head_data),
        .overrun_o   (overrun_o)
    );

    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD        (BAUD)
    ) uart_tx_inst (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .avail_i     (avail),
        .head_data_i (head_data),
        .cts_i       (cts_i),
        .take_o      (take),
        .txd_o       (txd_o)
    );

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

// 8n1 serial transmitter, pulls bytes from the buffer head
module uart_tx
    import uart_echo_pkg::*;
#(
    parameter int CLK_FREQ_HZ = 56060610,
    parameter int BAUD        = 9600
) (
    input  logic       clk_i,
    input  logic       rst_n,
    input  logic       avail_i,     // buffer not empty
    input  uart_byte_t head_data_i, // byte to send next
    input  logic       cts_i,       // clear to send, checked between frames only
    output logic       take_o,      // one cycle, consumes head
    output logic       txd_o        // serial out
);

    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W        = $clog2(DATA_BITS);

    frame_phase_t     phase_q;
    logic [CNT_W-1:0] bit_cnt_q;  // clocks within current bit
    logic [IDX_W-1:0] bit_idx_q;  // data bits already sent
    uart_byte_t       shift_q;    // remaining data, bit 0 goes next
    logic             txd_q;      // registered line driver

    logic bit_end;

    assign bit_end = (bit_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    // start a frame only from idle with data and permission
    assign take_o = (phase_q == PH_IDLE) && avail_i && cts_i;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            phase_q   <= PH_IDLE;
            bit_cnt_q <= '0;
            bit_idx_q <= '0;
            txd_q     <= LINE_IDLE;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    bit_cnt_q <= '0;
                    if (take_o) begin
                        phase_q <= PH_START;
                        txd_q   <= ~LINE_IDLE; // start bit from next cycle
                    end
                end

                PH_START: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        bit_idx_q <= '0;
                        phase_q   <= PH_DATA;
                        txd_q     <= shift_q[0]; // lsb first
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                PH_DATA: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        if (bit_idx_q == IDX_W'(DATA_BITS - 1)) begin
                            phase_q <= PH_STOP;
                            txd_q   <= LINE_IDLE; // stop bit
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            txd_q     <= shift_q[1]; // next bit before the shift lands
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                PH_STOP: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        phase_q   <= PH_IDLE; // next take one cycle later
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // byte latch and shifter
    always_ff @(posedge clk_i) begin
        if (take_o) begin
            shift_q <= head_data_i;
        end else if (phase_q == PH_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[DATA_BITS-1:1]};
        end
    end

    assign txd_o = txd_q;

    a_take_with_avail : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        take_o |-> avail_i
    );

    // line must rest high between frames
    a_idle_line_high : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        (phase_q == PH_IDLE) |-> (txd_o == LINE_IDLE)
    );

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// circular byte buffer between receiver and transmitter
// FIFO_DEPTH must be a power of two, at least 2
module byte_fifo
    import uart_echo_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n,
    input  logic       wr_valid_i,  // one-cycle write strobe
    input  uart_byte_t wr_data_i,
    input  logic       take_i,      // consume head
    output logic       avail_o,     // not empty
    output uart_byte_t head_data_o, // oldest byte
    output logic       overrun_o    // sticky, write lost at full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1; // holds 0..FIFO_DEPTH

    uart_byte_t       mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;     // wraps naturally, depth is 2**n
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;      // occupancy
    logic             overrun_q;

    logic full;
    logic wr_en;  // write actually accepted
    logic rd_en;  // head actually consumed

    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    assign avail_o = (count_q != '0);
    assign wr_en   = wr_valid_i && !full;
    assign rd_en   = take_i && avail_o;

    // storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            overrun_q <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // none, or both at once
            endcase
            if (wr_valid_i && full) begin
                overrun_q <= 1'b1; // byte is gone, no back-pressure to line
            end
        end
    end

    assign head_data_o = mem_q[rd_ptr_q];
    assign overrun_o   = overrun_q;

    // consumer side must honour the avail level
    a_take_needs_avail : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        take_i |-> avail_o
    );

    a_count_bound : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        count_q <= CNT_W'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

// 8n1 serial receiver
// samples each bit at its middle, counted from the falling edge of start
module uart_rx
    import uart_echo_pkg::*;
#(
    parameter int CLK_FREQ_HZ = 56060610,
    parameter int BAUD        = 9600
) (
    input  logic       clk_i,
    input  logic       rst_n,
    input  logic       rxd_i,       // async serial in
    output logic       rx_valid_o,  // one cycle per good frame
    output uart_byte_t rx_data_o,   // valid with rx_valid_o
    output logic       frame_err_o  // sticky, bad stop bit seen
);

    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W        = $clog2(DATA_BITS);

    logic             rxd_meta;    // first sync stage
    logic             rxd_sync;    // second sync stage, safe to use
    frame_phase_t     phase_q;
    logic [CNT_W-1:0] bit_cnt_q;   // clocks within current bit
    logic [IDX_W-1:0] bit_idx_q;   // data bit number
    uart_byte_t       shift_q;     // incoming bits, lsb arrives first
    logic             rx_valid_q;
    logic             frame_err_q;

    logic start_mid;  // middle of start bit reached
    logic bit_end;    // middle of a data or stop bit reached

    assign start_mid = (bit_cnt_q == CNT_W'(HALF_BIT - 1));
    assign bit_end   = (bit_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    // two-flop synchronizer, plus the frame fsm
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta    <= LINE_IDLE; // no false start out of reset
            rxd_sync    <= LINE_IDLE;
            phase_q     <= PH_IDLE;
            bit_cnt_q   <= '0;
            bit_idx_q   <= '0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rxd_meta   <= rxd_i;
            rxd_sync   <= rxd_meta;
            rx_valid_q <= 1'b0; // default, pulse only

            case (phase_q)
                PH_IDLE: begin
                    bit_cnt_q <= '0;
                    if (rxd_sync != LINE_IDLE) begin // falling edge
                        phase_q <= PH_START;
                    end
                end

                PH_START: begin
                    if (start_mid) begin
                        bit_cnt_q <= '0;
                        bit_idx_q <= '0;
                        // still low at mid-bit, otherwise a glitch
                        if (rxd_sync != LINE_IDLE) begin
                            phase_q <= PH_DATA;
                        end else begin
                            phase_q <= PH_IDLE;
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                PH_DATA: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        if (bit_idx_q == IDX_W'(DATA_BITS - 1)) begin
                            phase_q <= PH_STOP; // last data bit taken
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                PH_STOP: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        phase_q   <= PH_IDLE;
                        if (rxd_sync == LINE_IDLE) begin
                            rx_valid_q <= 1'b1;  // good frame
                        end else begin
                            frame_err_q <= 1'b1; // drop byte, flag it
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end

                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // data shift register, shifts right so bit 0 ends up lsb
    always_ff @(posedge clk_i) begin
        if (phase_q == PH_DATA && bit_end) begin
            shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
        end
    end

    assign rx_valid_o  = rx_valid_q;
    assign rx_data_o   = shift_q;     // stable until next frame's data phase
    assign frame_err_o = frame_err_q;

    // a frame lasts many clocks, so valid can never repeat back to back
    a_rx_valid_single : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        rx_valid_o |=> !rx_valid_o
    );

endmodule

`default_nettype wire

//--- hdl/uart_echo_pkg.sv
`default_nettype none

// shared by receiver, buffer, transmitter and top
package uart_echo_pkg;

    // 8n1 framing
    localparam int   DATA_BITS = 8;    // data bits per frame
    localparam logic LINE_IDLE = 1'b1; // line rest level, also the stop bit

    // one byte on its way rx -> fifo -> tx
    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // where a frame currently is, used by rx and tx alike
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0, // line at rest
        PH_START = 2'd1, // start bit
        PH_DATA  = 2'd2, // data bits, lsb first
        PH_STOP  = 2'd3  // stop bit
    } frame_phase_t;

endpackage

`default_nettype wire
